/* hw/mio_pkg.sv */
/*
 * Shared word format and width codes for the parallel-IO receive path.
 * A frame is one header word followed by hdr.len data words.
 * Header field widths must add up to the 64-bit word.
 * iowidth codes are fixed by the IO side and must not be renumbered.
 */
package mio_pkg;

   // ########################################
   // word geometry
   // ########################################

   localparam int MIO_LANES = 8;           // byte lanes per word

   // header fields, msb first
   localparam int HDR_CMD_W  = 8;          // command
   localparam int HDR_LEN_W  = 8;          // data words after the header
   localparam int HDR_ADDR_W = 48;         // target address

   // ########################################
   // io bus width codes (iowidth port)
   // ########################################

   localparam logic [1:0] IOW_8  = 2'd0;   // one lane per beat
   localparam logic [1:0] IOW_16 = 2'd1;   // two lanes per beat
   localparam logic [1:0] IOW_32 = 2'd2;   // four lanes
   localparam logic [1:0] IOW_64 = 2'd3;   // whole word per beat

   // ########################################
   // word type
   // ########################################

   // same 64 bits, decoded as header or as raw data
   // depending on where the word sits in the frame
   typedef union packed {
      logic [MIO_LANES*8-1:0] data_word;   // raw view, lane 0 in bits 7:0
      struct packed {
         logic [HDR_CMD_W-1:0]  cmd;       // bits 63:56
         logic [HDR_LEN_W-1:0]  len;       // bits 55:48
         logic [HDR_ADDR_W-1:0] addr;      // bits 47:0
      } hdr;                               // header view, first word only
   } mio_word_u;

   // first beat of a frame lands in lane 0
   // later beats move upward lane by lane

endpackage

/* hw/mrx_io.sv */
/*
 * SDR capture of the IO bus and packing of beats into 64-bit words.
 * iowidth must not select a bus wider than IOW and must stay constant
 * while a frame is active or still being packed.
 * Frames need at least one idle cycle of rx_access between them.
 * No flow control toward the IO side. Words are pushed unconditionally.
 */
`timescale 1ns/1ns

module mrx_io #(
   parameter int IOW = 64                          // physical io bus width
) (
   input  logic                          rx_clk,
   input  logic                          io_nreset,
   input  logic [1:0]                    iowidth,  // run time bus width code
   input  logic                          rx_access,
   input  logic [IOW-1:0]                rx_packet,
   output logic                          io_access, // push strobe to fifo
   output logic [mio_pkg::MIO_LANES-1:0] io_valid,  // running lane mask
   output logic [63:0]                   io_packet,
   output logic                          io_last    // word closes the frame
);
   import mio_pkg::*;

   logic [IOW-1:0]       sdr_data;        // captured beat
   logic                 io_frame;        // rx_access, one cycle late
   logic [63:0]          beat;            // beat widened to a word
   logic [63:0]          mux_data;        // beat copied into every lane group
   logic [MIO_LANES-1:0] valid_input;     // lanes of the first beat
   logic [MIO_LANES-1:0] valid_next;      // mask after one more beat
   logic [MIO_LANES-1:0] data_select;     // lanes written this cycle
   logic                 reload;
   logic                 transfer_active;
   logic                 transfer_done;
   logic [63:0]          shiftreg;

   // ########################################
   // capture
   // ########################################

   always_ff @(posedge rx_clk) begin
      if (rx_access) begin
         sdr_data <= rx_packet;
      end
   end

   always_ff @(posedge rx_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         io_frame <= 1'b0;
      end else begin
         io_frame <= rx_access;
      end
   end

   // upper bits zero when IOW < 64
   always_comb begin
      beat = '0;
      beat[IOW-1:0] = sdr_data;
   end

   // replicate so any lane group can pick up the beat
   always_comb begin
      case (iowidth)
         IOW_8:   mux_data = {8{beat[7:0]}};
         IOW_16:  mux_data = {4{beat[15:0]}};
         IOW_32:  mux_data = {2{beat[31:0]}};
         default: mux_data = beat;
      endcase
   end

   // ########################################
   // lane tracking
   // ########################################

   always_comb begin
      case (iowidth)
         IOW_8: begin
            valid_input = 8'h01;
            valid_next  = {io_valid[6:0], 1'b1};
         end
         IOW_16: begin
            valid_input = 8'h03;
            valid_next  = {io_valid[5:0], 2'b11};
         end
         IOW_32: begin
            valid_input = 8'h0f;
            valid_next  = {io_valid[3:0], 4'hf};
         end
         default: begin
            valid_input = 8'hff;          // one beat fills the word
            valid_next  = 8'hff;
         end
      endcase
   end

   assign transfer_active = |io_valid;
   assign transfer_done   = &io_valid;

   // start over at a new frame or once the word is full
   assign reload = io_frame & (transfer_done | ~transfer_active);

   always_ff @(posedge rx_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         io_valid <= '0;
      end else if (reload) begin
         io_valid <= valid_input;
      end else if (io_frame) begin
         io_valid <= valid_next;
      end else begin
         io_valid <= '0;                  // idle, or partial word just pushed
      end
   end

   // ########################################
   // packer
   // ########################################

   // only the lanes that this beat adds
   assign data_select = reload   ? valid_input :
                        io_frame ? (valid_next & ~io_valid) :
                                   '0;

   always_ff @(posedge rx_clk) begin
      for (int i = 0; i < MIO_LANES; i++) begin
         if (data_select[i]) begin
            shiftreg[i*8 +: 8] <= mux_data[i*8 +: 8];
         end
      end
   end

   assign io_packet = shiftreg;

   // full word, or leftover lanes once the frame has dropped
   assign io_access = transfer_done | (~io_frame & transfer_active);
   assign io_last   = ~io_frame & transfer_active;

   // width code may not move under a frame in progress
   a_iowidth_stable: assert property (
      @(posedge rx_clk) disable iff (!io_nreset)
      (io_frame || (|io_valid)) |-> $stable(iowidth)
   ) else $error("iowidth changed during a frame");

endmodule

/* hw/mrx_fifo.sv */
/*
 * Single-clock word FIFO between packer and unpacker.
 * FIFO_DEPTH must be a power of two and at least 2.
 * A push into a full FIFO is lost and latches overflow until reset.
 * The head entry is valid whenever empty is low.
 */
`timescale 1ns/1ns

module mrx_fifo #(
   parameter int FIFO_DEPTH = 8                      // entries, power of two
) (
   input  logic                          rx_clk,
   input  logic                          io_nreset,
   input  logic                          push,
   input  mio_pkg::mio_word_u            push_word,
   input  logic [mio_pkg::MIO_LANES-1:0] push_valid,
   input  logic                          push_last,
   input  logic                          pop,
   output mio_pkg::mio_word_u            rd_word,    // head entry
   output logic [mio_pkg::MIO_LANES-1:0] rd_valid,
   output logic                          rd_last,
   output logic                          empty,
   output logic                          full,
   output logic                          overflow    // sticky
);
   import mio_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);

   mio_word_u            mem_word  [FIFO_DEPTH];
   logic [MIO_LANES-1:0] mem_valid [FIFO_DEPTH];
   logic                 mem_last  [FIFO_DEPTH];
   logic [AW:0]          wr_ptr;    // extra msb tells full from empty
   logic [AW:0]          rd_ptr;
   logic                 wr_en;

   // ########################################
   // status
   // ########################################

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);   // one lap ahead

   assign wr_en = push & ~full;          // drop when full

   // ########################################
   // storage
   // ########################################

   always_ff @(posedge rx_clk) begin
      if (wr_en) begin
         mem_word[wr_ptr[AW-1:0]]  <= push_word;
         mem_valid[wr_ptr[AW-1:0]] <= push_valid;
         mem_last[wr_ptr[AW-1:0]]  <= push_last;
      end
   end

   // head is read straight from the array
   assign rd_word  = mem_word[rd_ptr[AW-1:0]];
   assign rd_valid = mem_valid[rd_ptr[AW-1:0]];
   assign rd_last  = mem_last[rd_ptr[AW-1:0]];

   // ########################################
   // pointers and overflow
   // ########################################

   always_ff @(posedge rx_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;      // caller guarantees not empty
         end
         if (push && full) begin
            overflow <= 1'b1;             // held until reset
         end
      end
   end

   // consumer must look at empty before popping
   a_no_pop_empty: assert property (
      @(posedge rx_clk) disable iff (!io_nreset)
      pop |-> !empty
   ) else $error("pop while fifo empty");

endmodule

/* hw/mrx_unpack.sv */
/*
 * Drains the word FIFO and splits frames into header and data.
 * The first word after reset or after a last word is taken as a header.
 * Pops happen whenever a word is present and core_wait is low.
 * Outputs are registered, each strobe lasts one cycle.
 */
`timescale 1ns/1ns

module mrx_unpack (
   input  logic                           rx_clk,
   input  logic                           io_nreset,
   input  logic                           empty,
   input  mio_pkg::mio_word_u             rd_word,
   input  logic [mio_pkg::MIO_LANES-1:0]  rd_valid,
   input  logic                           rd_last,
   input  logic                           core_wait,   // stall level from core
   output logic                           pop,
   output logic                           hdr_strobe,
   output logic [mio_pkg::HDR_CMD_W-1:0]  hdr_cmd,
   output logic [mio_pkg::HDR_LEN_W-1:0]  hdr_len,
   output logic [mio_pkg::HDR_ADDR_W-1:0] hdr_addr,
   output logic                           data_strobe,
   output logic [63:0]                    data,
   output logic [mio_pkg::MIO_LANES-1:0]  data_be,     // filled lanes only
   output logic                           frame_end    // with last data word
);

   logic in_frame;     // high once a header has been taken
   logic hdr_pop;
   logic data_pop;

   // ########################################
   // pop and decode select
   // ########################################

   assign pop      = ~empty & ~core_wait;
   assign hdr_pop  = pop & ~in_frame;
   assign data_pop = pop & in_frame;

   // ########################################
   // control
   // ########################################

   always_ff @(posedge rx_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         in_frame    <= 1'b0;
         hdr_strobe  <= 1'b0;
         data_strobe <= 1'b0;
         frame_end   <= 1'b0;
      end else begin
         hdr_strobe  <= hdr_pop;
         data_strobe <= data_pop;
         frame_end   <= data_pop & rd_last;
         if (pop) begin
            // a last word closes the frame, header-only frames included
            in_frame <= ~rd_last;
         end
      end
   end

   // ########################################
   // payload
   // ########################################

   always_ff @(posedge rx_clk) begin
      if (hdr_pop) begin
         hdr_cmd  <= rd_word.hdr.cmd;      // header view of the union
         hdr_len  <= rd_word.hdr.len;
         hdr_addr <= rd_word.hdr.addr;
      end
      if (data_pop) begin
         data    <= rd_word.data_word;     // raw view
         data_be <= rd_valid;
      end
   end

   // one word per pop, so one kind of strobe per cycle
   a_strobe_onehot: assert property (
      @(posedge rx_clk) disable iff (!io_nreset)
      !(hdr_strobe && data_strobe)
   ) else $error("header and data strobes together");

endmodule

/* hw/mrx_top.sv */
/*
 * Receive side of the parallel-IO link, single rx_clk domain.
 * IOW sets the physical bus, iowidth picks the active part at run time.
 * overflow flags lost words and is cleared only by reset.
 */
`timescale 1ns/1ns

module mrx_top #(
   parameter int IOW        = 64,        // io bus width
   parameter int FIFO_DEPTH = 8          // words buffered, power of two
) (
   input  logic                           rx_clk,
   input  logic                           io_nreset,
   input  logic [1:0]                     iowidth,
   input  logic                           rx_access,
   input  logic [IOW-1:0]                 rx_packet,
   input  logic                           core_wait,
   output logic                           hdr_strobe,
   output logic [mio_pkg::HDR_CMD_W-1:0]  hdr_cmd,
   output logic [mio_pkg::HDR_LEN_W-1:0]  hdr_len,
   output logic [mio_pkg::HDR_ADDR_W-1:0] hdr_addr,
   output logic                           data_strobe,
   output logic [63:0]                    data,
   output logic [mio_pkg::MIO_LANES-1:0]  data_be,
   output logic                           frame_end,
   output logic                           overflow
);
   import mio_pkg::*;

   // packer to fifo
   logic                 io_access;
   logic [MIO_LANES-1:0] io_valid;
   logic [63:0]          io_packet;
   logic                 io_last;

   // fifo to unpacker
   mio_word_u            rd_word;
   logic [MIO_LANES-1:0] rd_valid;
   logic                 rd_last;
   logic                 empty;
   logic                 pop;

   // ########################################
   // datapath
   // ########################################

   mrx_io #(.IOW(IOW)) mrx_io_i (
      .rx_clk    (rx_clk),
      .io_nreset (io_nreset),
      .iowidth   (iowidth),
      .rx_access (rx_access),
      .rx_packet (rx_packet),
      .io_access (io_access),
      .io_valid  (io_valid),
      .io_packet (io_packet),
      .io_last   (io_last)
   );

   mrx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) mrx_fifo_i (
      .rx_clk     (rx_clk),
      .io_nreset  (io_nreset),
      .push       (io_access),
      .push_word  (io_packet),
      .push_valid (io_valid),
      .push_last  (io_last),
      .pop        (pop),
      .rd_word    (rd_word),
      .rd_valid   (rd_valid),
      .rd_last    (rd_last),
      .empty      (empty),
      .full       (),               // only needed inside the fifo
      .overflow   (overflow)
   );

   mrx_unpack mrx_unpack_i (
      .rx_clk      (rx_clk),
      .io_nreset   (io_nreset),
      .empty       (empty),
      .rd_word     (rd_word),
      .rd_valid    (rd_valid),
      .rd_last     (rd_last),
      .core_wait   (core_wait),
      .pop         (pop),
      .hdr_strobe  (hdr_strobe),
      .hdr_cmd     (hdr_cmd),
      .hdr_len     (hdr_len),
      .hdr_addr    (hdr_addr),
      .data_strobe (data_strobe),
      .data        (data),
      .data_be     (data_be),
      .frame_end   (frame_end)
   );

endmodule

/* verification/mrx_tb.sv */
/*
 * Testbench for the receive path with IOW=64 and FIFO_DEPTH=8.
 * Frames are built from random bytes and the expected header and data words
 * are queued in send order. Assertions compare each strobe with its queue head.
 * The overflow test leaves the unpacker mid-frame and must stay last.
 */
`timescale 1ns/1ns

module mrx_tb;
   import mio_pkg::*;

   localparam int IOW        = 64;
   localparam int FIFO_DEPTH = 8;
   localparam int WD_MARGIN  = 500;          // cycles on top of the beat budget

   typedef struct packed {
      logic [63:0]          word;
      logic [MIO_LANES-1:0] be;
      logic                 last;
   } data_exp_t;

   logic                  rx_clk;
   logic                  io_nreset;
   logic [1:0]            iowidth;
   logic                  rx_access;
   logic [IOW-1:0]        rx_packet;
   logic                  core_wait;
   logic                  hdr_strobe;
   logic [HDR_CMD_W-1:0]  hdr_cmd;
   logic [HDR_LEN_W-1:0]  hdr_len;
   logic [HDR_ADDR_W-1:0] hdr_addr;
   logic                  data_strobe;
   logic [63:0]           data;
   logic [MIO_LANES-1:0]  data_be;
   logic                  frame_end;
   logic                  overflow;

   logic [63:0] hdr_q[$];                   // expected headers, {cmd, len, addr}
   data_exp_t   data_q[$];                  // expected data words in order
   logic [63:0] exp_hdr;                    // head taken for the current strobe
   logic        exp_hdr_ok = 1'b0;
   data_exp_t   exp_dat;
   logic        exp_dat_ok = 1'b0;
   logic [1:0]  ovf_check  = 2'd0;          // 0 free, 1 must be low, 2 must be high
   int          errors       = 0;
   int          err_base     = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          sent_beats   = 0;

   mrx_top #(.IOW(IOW), .FIFO_DEPTH(FIFO_DEPTH)) mrx_top_i (
      .rx_clk      (rx_clk),
      .io_nreset   (io_nreset),
      .iowidth     (iowidth),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .core_wait   (core_wait),
      .hdr_strobe  (hdr_strobe),
      .hdr_cmd     (hdr_cmd),
      .hdr_len     (hdr_len),
      .hdr_addr    (hdr_addr),
      .data_strobe (data_strobe),
      .data        (data),
      .data_be     (data_be),
      .frame_end   (frame_end),
      .overflow    (overflow)
   );

   // ########################################
   // clock and watchdog
   // ########################################

   initial begin
      rx_clk = 1'b0;
      forever #5 rx_clk = ~rx_clk;
   end

   // budget grows with every beat sent
   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles <= 200 * sent_beats + WD_MARGIN) begin
         @(posedge rx_clk);
         cycles++;
      end
      $display("timeout after %0d cycles, expected words never arrived", cycles);
      $display("=== FAIL ===");
      $finish;
   end

   // ########################################
   // helpers
   // ########################################

   function automatic logic [63:0] rand64();
      logic [31:0] lo;
      logic [31:0] hi;
      lo = $urandom;
      hi = $urandom;
      return {hi, lo};
   endfunction

   // byte enables widened to bit mask
   function automatic logic [63:0] lane_mask(input logic [MIO_LANES-1:0] be);
      logic [63:0] m;
      int          i;
      for (i = 0; i < MIO_LANES; i++) begin
         m[8*i +: 8] = {8{be[i]}};
      end
      return m;
   endfunction

   // header plus len data words, last one holds tail bytes
   task automatic send_frame(input logic [1:0] width, input int len, input int tail);
      logic [7:0]  bytes[$];
      logic [63:0] hdr;
      logic [63:0] word;
      logic [63:0] pkt;
      data_exp_t   entry;
      int          lanes;
      int          nb;
      int          idx;
      int          w;
      int          i;
      lanes = 1 << width;                   // bytes per beat
      if (iowidth !== width) begin
         repeat (3) @(negedge rx_clk);      // packer idle before the switch
         iowidth = width;
      end
      hdr = rand64();
      hdr[55:48] = len[7:0];                // cmd 63:56, len 55:48, addr 47:0
      hdr_q.push_back(hdr);
      for (i = 0; i < 8; i++) begin
         bytes.push_back(hdr[8*i +: 8]);    // lane 0 goes out first
      end
      for (w = 0; w < len; w++) begin
         nb   = (w == len - 1) ? tail : 8;
         word = rand64();
         for (i = 0; i < nb; i++) begin
            bytes.push_back(word[8*i +: 8]);
         end
         entry.word = word;
         entry.be   = 8'hff >> (8 - nb);    // filled lanes from the bottom
         entry.last = (w == len - 1);
         data_q.push_back(entry);
      end
      idx = 0;
      while (idx < bytes.size()) begin
         @(negedge rx_clk);
         pkt = rand64();                    // lanes above the width are noise
         for (i = 0; i < lanes; i++) begin
            pkt[8*i +: 8] = bytes[idx];
            idx++;
         end
         rx_access = 1'b1;
         rx_packet = pkt;
         sent_beats++;
      end
      @(negedge rx_clk);
      rx_access = 1'b0;                     // one idle cycle ends the frame
      rx_packet = rand64();
   endtask

   task automatic start_test();
      err_base = errors;
      tests_run++;
   endtask

   // wait for every queued word, then report
   task automatic end_test(input string name);
      while (hdr_q.size() != 0 || data_q.size() != 0) begin
         @(negedge rx_clk);
      end
      repeat (4) @(negedge rx_clk);         // last strobe checked by now
      if (errors == err_base) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
      end
   endtask

   // ########################################
   // checking
   // ########################################

   // strobes are stable mid-cycle, latch the matching queue head
   always @(negedge rx_clk) begin
      if (hdr_strobe) begin
         exp_hdr_ok = (hdr_q.size() != 0);
         if (exp_hdr_ok) begin
            exp_hdr = hdr_q.pop_front();
         end
      end
      if (data_strobe) begin
         exp_dat_ok = (data_q.size() != 0);
         if (exp_dat_ok) begin
            exp_dat = data_q.pop_front();
         end
      end
   end

   a_hdr_expected: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      hdr_strobe |-> exp_hdr_ok)
   else begin
      errors++;
      $display("Error: header strobe arrived with no header expected");
   end

   a_hdr_cmd: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      hdr_strobe && exp_hdr_ok |-> hdr_cmd == exp_hdr[63:56])
   else begin
      errors++;
      $display("Error: hdr_cmd expected %h got %h", exp_hdr[63:56], $sampled(hdr_cmd));
   end

   a_hdr_len: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      hdr_strobe && exp_hdr_ok |-> hdr_len == exp_hdr[55:48])
   else begin
      errors++;
      $display("Error: hdr_len expected %h got %h", exp_hdr[55:48], $sampled(hdr_len));
   end

   a_hdr_addr: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      hdr_strobe && exp_hdr_ok |-> hdr_addr == exp_hdr[47:0])
   else begin
      errors++;
      $display("Error: hdr_addr expected %h got %h", exp_hdr[47:0], $sampled(hdr_addr));
   end

   a_data_expected: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      data_strobe |-> exp_dat_ok)
   else begin
      errors++;
      $display("Error: data strobe arrived with no data word expected");
   end

   // unfilled lanes are don't care
   a_data_value: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      data_strobe && exp_dat_ok |->
         (data & lane_mask(exp_dat.be)) == (exp_dat.word & lane_mask(exp_dat.be)))
   else begin
      errors++;
      $display("Error: data expected %h got %h mask %h", exp_dat.word,
               $sampled(data), lane_mask(exp_dat.be));
   end

   a_data_be: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      data_strobe && exp_dat_ok |-> data_be == exp_dat.be)
   else begin
      errors++;
      $display("Error: data_be expected %h got %h", exp_dat.be, $sampled(data_be));
   end

   a_frame_end: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      data_strobe && exp_dat_ok |-> frame_end == exp_dat.last)
   else begin
      errors++;
      $display("Error: frame_end expected %h got %h", exp_dat.last, $sampled(frame_end));
   end

   // a full cycle of core_wait means no pop, so no strobe
   a_no_strobe_wait: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      core_wait && $past(core_wait) |-> !hdr_strobe && !data_strobe)
   else begin
      errors++;
      $display("Error: strobe seen while core_wait was held");
   end

   a_ovf_low: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      ovf_check == 2'd1 |-> !overflow)
   else begin
      errors++;
      $display("Error: overflow expected %h got %h", 1'b0, $sampled(overflow));
   end

   a_ovf_high: assert property (@(posedge rx_clk) disable iff (!io_nreset)
      ovf_check == 2'd2 |-> overflow)
   else begin
      errors++;
      $display("Error: overflow expected %h got %h", 1'b1, $sampled(overflow));
   end

   // ########################################
   // tests
   // ########################################

   initial begin : main
      int len;
      io_nreset = 1'b0;
      iowidth   = IOW_64;
      rx_access = 1'b0;
      rx_packet = '0;
      core_wait = 1'b0;
      void'($urandom(32'h21df_5f24));
      repeat (3) @(posedge rx_clk);
      @(negedge rx_clk);
      io_nreset = 1'b1;
      ovf_check = 2'd1;

      start_test();
      send_frame(IOW_64, 6, 8);
      end_test("64-bit header decode");

      start_test();
      send_frame(IOW_8, 3, 8);
      send_frame(IOW_16, 4, 8);
      end_test("8/16-bit repacking");

      start_test();
      send_frame(IOW_8, 3, 3);              // 27 bytes
      send_frame(IOW_16, 2, 6);             // 22 bytes
      end_test("partial last word");

      start_test();
      send_frame(IOW_32, 3, 8);
      send_frame(IOW_32, 2, 4);             // one idle cycle between frames
      end_test("32-bit back to back frames");

      start_test();
      @(negedge rx_clk);
      core_wait = 1'b1;
      send_frame(IOW_64, 5, 8);             // 6 words fit in the fifo
      repeat (20) @(negedge rx_clk);
      core_wait = 1'b0;
      end_test("core_wait within fifo depth");

      start_test();
      @(negedge rx_clk);
      core_wait = 1'b1;
      ovf_check = 2'd0;                     // fill phase, either level
      len = 12;
      send_frame(IOW_64, len, 8);
      while (data_q.size() > FIFO_DEPTH - 1) begin
         void'(data_q.pop_back());          // words past the fifo are lost
      end
      repeat (10) @(negedge rx_clk);
      if (len + 1 > FIFO_DEPTH) begin
         ovf_check = 2'd2;                  // sticky from here on
      end
      core_wait = 1'b0;
      end_test("overflow past fifo depth");

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* build.f */
hw/mio_pkg.sv
hw/mrx_io.sv
hw/mrx_fifo.sv
hw/mrx_unpack.sv
hw/mrx_top.sv
verification/mrx_tb.sv

/* Makefile */
# Verilator build and run of the receive path testbench

VERILATOR ?= verilator
TOP       ?= mrx_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '=== FAIL ===' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '=== PASS ===' $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
